/* hdl/kl_mem_pkg.sv */
package kl_mem_pkg;

  // Memory word and physical address widths
  localparam int word_w = 36;
  localparam int pma_w  = 22;

  // 36-bit memory data word
  typedef logic [word_w-1:0] word_t;

  // 22-bit physical memory address
  typedef logic [pma_w-1:0] pma_t;

  // Diagnostic mode for parity fault injection
  typedef logic [1:0] diag_t;

  // Invert address parity toward memory
  localparam diag_t diag_adr_par_inv  = 2'd1;
  // Invert data parity on a write
  localparam diag_t diag_data_par_inv = 2'd2;

  // Populated words, anything at or above is nonexistent memory
  localparam int mem_words = 1024;
  localparam int mem_aw    = $clog2(mem_words);

  // Cycles from start to acknowledge
  localparam int ackn_delay  = 2;
  // Cycles from acknowledge to data valid
  localparam int data_delay  = 2;
  // Cycles to wait for an acknowledge before calling it NXM
  localparam int nxm_timeout = 16;

  // Down counter wide enough for the longest wait
  typedef logic [$clog2(nxm_timeout):0] tmr_t;

  // MBOX memory cycle sequencer
  typedef enum logic [2:0] {
    idle,
    start,
    wait_ackn,
    wait_data,
    done
  } ctl_state_t;

endpackage

/* hdl/mbox_if.sv */
interface mbox_if;
  import kl_mem_pkg::*;

  // Cycle control from the MBOX
  logic  mem_start;
  logic  mem_rd_rq;
  logic  mem_wr_rq;
  logic  addr_hold;
  pma_t  pma;
  diag_t diag;

  // Write data path, MBOX toward memory
  word_t mb;
  logic  data_to_mem;
  logic  data_valid_out;

  // Responses back from the translator
  logic  mem_ackn;
  logic  mem_error;
  logic  mem_adr_par_err;

  // Read data path, memory toward MBOX
  logic  mem_data_valid_in;
  word_t mem_data_in;
  logic  mem_par_in;

  modport ctl (
    output mem_start, mem_rd_rq, mem_wr_rq, addr_hold, pma, diag,
    output mb, data_to_mem, data_valid_out,
    input  mem_ackn, mem_error, mem_adr_par_err,
    input  mem_data_valid_in, mem_data_in, mem_par_in
  );

  modport xlat (
    input  mem_start, mem_rd_rq, mem_wr_rq, addr_hold, pma, diag,
    input  mb, data_to_mem, data_valid_out,
    output mem_ackn, mem_error, mem_adr_par_err,
    output mem_data_valid_in, mem_data_in, mem_par_in
  );

endinterface

/* hdl/sbus_if.sv */
interface sbus_if;
  import kl_mem_pkg::*;

  // Cycle request, single cable port
  logic  start;
  logic  rd_rq;
  logic  wr_rq;

  // Held physical address and its parity
  pma_t  adr;
  logic  adr_par;

  // Write data set, translator to memory
  word_t d_to_mem;
  logic  data_par_to_mem;
  logic  data_valid_to_mem;

  // Memory responses
  logic  ackn;
  logic  error;
  logic  adr_par_err;

  // Read data set, memory to translator
  word_t d_from_mem;
  logic  data_par_from_mem;
  logic  data_valid_from_mem;

  // Translator side
  modport mbox (
    output start, rd_rq, wr_rq, adr, adr_par,
    output d_to_mem, data_par_to_mem, data_valid_to_mem,
    input  ackn, error, adr_par_err,
    input  d_from_mem, data_par_from_mem, data_valid_from_mem
  );

  // Memory module side
  modport mem (
    input  start, rd_rq, wr_rq, adr, adr_par,
    input  d_to_mem, data_par_to_mem, data_valid_to_mem,
    output ackn, error, adr_par_err,
    output d_from_mem, data_par_from_mem, data_valid_from_mem
  );

endinterface

/* hdl/mbox_mem_ctl.sv */
module mbox_mem_ctl (
  input  logic               sbus_clk,
  input  logic               reset,
  input  logic               rq,
  input  logic               wr,
  input  kl_mem_pkg::pma_t   addr,
  input  kl_mem_pkg::word_t  wdata,
  input  kl_mem_pkg::diag_t  diag,
  output logic               busy,
  output logic               done,
  output kl_mem_pkg::word_t  rdata,
  output logic               par_err,
  output logic               adr_par_err,
  output logic               nxm,
  mbox_if.ctl                mbx
);
  import kl_mem_pkg::*;

  ctl_state_t state;
  tmr_t       cnt;
  logic       accept;
  logic       start_strobe;
  logic       req_wr;
  pma_t       req_addr;
  word_t      req_data;
  diag_t      req_diag;

  // Busy from start through the data phase, low again in done
  assign busy = (state == start) || (state == wait_ackn) || (state == wait_data);

  // The port named done hides the state literal, so scope it
  assign done = (state == kl_mem_pkg::done);

  // New request only taken while not busy
  assign accept = rq && !busy;

  // Start and address hold go out together, one cycle after accept
  assign mbx.mem_start = start_strobe;
  assign mbx.addr_hold = start_strobe;

  // Direction levels stay up for the whole cycle
  assign mbx.mem_rd_rq   = busy && !req_wr;
  assign mbx.mem_wr_rq   = busy && req_wr;
  assign mbx.data_to_mem = req_wr;

  assign mbx.pma  = req_addr;
  assign mbx.mb   = req_data;
  assign mbx.diag = req_diag;

  // Write strobe lands data_delay cycles after the acknowledge
  assign mbx.data_valid_out = (state == wait_data) && req_wr && (cnt == '0);

  always_ff @(posedge sbus_clk) begin
    if (reset) begin
      state        <= idle;
      cnt          <= '0;
      start_strobe <= 1'b0;
      req_wr       <= 1'b0;
      par_err      <= 1'b0;
      adr_par_err  <= 1'b0;
      nxm          <= 1'b0;
    end else begin
      start_strobe <= accept;
      case (state)
        idle, kl_mem_pkg::done: begin
          if (accept) begin
            state       <= start;
            req_wr      <= wr;
            // Flags describe only the cycle being started
            par_err     <= 1'b0;
            adr_par_err <= 1'b0;
            nxm         <= 1'b0;
          end else begin
            state <= idle;
          end
        end
        start: begin
          // NXM window counts from the start cycle itself
          state <= wait_ackn;
          cnt   <= tmr_t'(nxm_timeout - 2);
        end
        wait_ackn: begin
          if (mbx.mem_ackn) begin
            if (mbx.mem_error) begin
              // Aborted by memory, no data phase
              adr_par_err <= mbx.mem_adr_par_err;
              state       <= kl_mem_pkg::done;
            end else begin
              state <= wait_data;
              cnt   <= tmr_t'(data_delay - 1);
            end
          end else if (cnt == '0) begin
            // Nobody answered this address
            nxm   <= 1'b1;
            state <= kl_mem_pkg::done;
          end else begin
            cnt <= cnt - tmr_t'(1);
          end
        end
        wait_data: begin
          if (cnt != '0) begin
            cnt <= cnt - tmr_t'(1);
          end
          if (req_wr) begin
            // Write ends on our own strobe
            if (cnt == '0) state <= kl_mem_pkg::done;
          end else if (mbx.mem_data_valid_in) begin
            // Even parity over the returned word
            par_err <= (^mbx.mem_data_in) != mbx.mem_par_in;
            state   <= kl_mem_pkg::done;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // Request payload and read data capture
  always_ff @(posedge sbus_clk) begin
    if (accept) begin
      req_addr <= addr;
      req_data <= wdata;
      req_diag <= diag;
      rdata    <= '0;
    end else if ((state == wait_data) && !req_wr && mbx.mem_data_valid_in) begin
      rdata <= mbx.mem_data_in;
    end
  end

  // Start strobe register must line up with the start state
  a_start_in_state: assert property (@(posedge sbus_clk) disable iff (reset)
    start_strobe |-> state == start);

  // One done per cycle
  a_done_pulse: assert property (@(posedge sbus_clk) disable iff (reset)
    done |=> !done);

endmodule

/* hdl/mt0.sv */
module mt0 (
  input  logic  sbus_clk,
  input  logic  reset,
  mbox_if.xlat  mbx,
  sbus_if.mbox  sbus
);
  import kl_mem_pkg::*;

  pma_t adr_q;
  pma_t adr_cur;
  logic to_mem;

  assign to_mem = mbx.data_to_mem;

  // Address register replaces the old transparent latch
  always_ff @(posedge sbus_clk) begin
    if (reset) begin
      adr_q <= '0;
    end else if (mbx.addr_hold) begin
      adr_q <= mbx.pma;
    end
  end

  // Flow through while hold is up, as the latch did
  assign adr_cur = mbx.addr_hold ? mbx.pma : adr_q;

  // Cycle control passes straight to the bus
  assign sbus.start   = mbx.mem_start;
  assign sbus.rd_rq   = mbx.mem_rd_rq;
  assign sbus.wr_rq   = mbx.mem_wr_rq;
  assign sbus.adr     = adr_cur;
  // Even address parity, diag can flip it
  assign sbus.adr_par = (^adr_cur) ^ (mbx.diag == diag_adr_par_inv);

  // Write side, only live when data heads to memory
  assign sbus.d_to_mem          = to_mem ? mbx.mb : '0;
  assign sbus.data_par_to_mem   = to_mem && ((^mbx.mb) ^ (mbx.diag == diag_data_par_inv));
  assign sbus.data_valid_to_mem = to_mem && mbx.data_valid_out;

  // Read side, only live when data heads back to the MBOX
  assign mbx.mem_data_in       = to_mem ? '0 : sbus.d_from_mem;
  assign mbx.mem_par_in        = !to_mem && sbus.data_par_from_mem;
  assign mbx.mem_data_valid_in = !to_mem && sbus.data_valid_from_mem;

  // Acknowledge and errors come back unchanged
  assign mbx.mem_ackn        = sbus.ackn;
  assign mbx.mem_error       = sbus.error;
  assign mbx.mem_adr_par_err = sbus.adr_par_err;

  // Address load and write strobe belong to different phases of the cycle
  a_hold_vs_data: assert property (@(posedge sbus_clk) disable iff (reset)
    !(mbx.addr_hold && mbx.data_valid_out));

endmodule

/* hdl/sbus_mem.sv */
module sbus_mem (
  input  logic sbus_clk,
  input  logic reset,
  sbus_if.mem  sbus
);
  import kl_mem_pkg::*;

  typedef enum logic [1:0] {
    m_idle,
    m_ackn,
    m_data
  } mem_state_t;

  // Stored word with its parity bit on top
  logic [$bits(word_t):0] mem_array [mem_words];

  mem_state_t        mstate;
  tmr_t              cnt;
  logic              adr_bad;
  logic              exists;
  logic [mem_aw-1:0] row;

  // Only the low block of addresses is populated
  assign exists = sbus.adr < pma_t'(mem_words);
  assign row    = sbus.adr[mem_aw-1:0];

  // Acknowledge one cycle, error rides along when address parity failed
  assign sbus.ackn        = (mstate == m_ackn) && (cnt == '0);
  assign sbus.error       = sbus.ackn && adr_bad;
  assign sbus.adr_par_err = sbus.ackn && adr_bad;

  // Read data comes straight from the array, the strobe marks it
  assign {sbus.data_par_from_mem, sbus.d_from_mem} = mem_array[row];
  assign sbus.data_valid_from_mem = (mstate == m_data) && (cnt == '0) && sbus.rd_rq;

  always_ff @(posedge sbus_clk) begin
    if (reset) begin
      mstate  <= m_idle;
      cnt     <= '0;
      adr_bad <= 1'b0;
      // Contents start as zero with good parity
      for (int i = 0; i < mem_words; i++) begin
        mem_array[i] <= '0;
      end
    end else begin
      case (mstate)
        m_idle: begin
          // NXM addresses get no answer at all
          if (sbus.start && exists) begin
            mstate  <= m_ackn;
            cnt     <= tmr_t'(ackn_delay - 1);
            adr_bad <= (^sbus.adr) != sbus.adr_par;
          end
        end
        m_ackn: begin
          if (cnt != '0) begin
            cnt <= cnt - tmr_t'(1);
          end else if (adr_bad) begin
            // Bad address, cycle ends at the acknowledge
            mstate <= m_idle;
          end else begin
            mstate <= m_data;
            cnt    <= tmr_t'(data_delay - 1);
          end
        end
        m_data: begin
          if (cnt != '0) begin
            cnt <= cnt - tmr_t'(1);
          end else begin
            mstate <= m_idle;
            // Parity stored as sent, so a bad write reads back bad
            if (sbus.wr_rq && sbus.data_valid_to_mem) begin
              mem_array[row] <= {sbus.data_par_to_mem, sbus.d_to_mem};
            end
          end
        end
        default: mstate <= m_idle;
      endcase
    end
  end

  // Every acknowledge answers a start ackn_delay cycles back
  a_ackn_after_start: assert property (@(posedge sbus_clk) disable iff (reset)
    sbus.ackn |-> $past(sbus.start, ackn_delay));

endmodule

/* hdl/kl_mem_top.sv */
module kl_mem_top (
  input  logic               sbus_clk,
  input  logic               reset,
  input  logic               rq,
  input  logic               wr,
  input  kl_mem_pkg::pma_t   addr,
  input  kl_mem_pkg::word_t  wdata,
  input  kl_mem_pkg::diag_t  diag,
  output logic               busy,
  output logic               done,
  output kl_mem_pkg::word_t  rdata,
  output logic               par_err,
  output logic               adr_par_err,
  output logic               nxm
);

  // MBOX to translator
  mbox_if mbx_bus ();

  // Translator to memory
  sbus_if sbus_bus ();

  // Memory cycle controller, client side
  mbox_mem_ctl u_ctl (
    .sbus_clk    (sbus_clk),
    .reset       (reset),
    .rq          (rq),
    .wr          (wr),
    .addr        (addr),
    .wdata       (wdata),
    .diag        (diag),
    .busy        (busy),
    .done        (done),
    .rdata       (rdata),
    .par_err     (par_err),
    .adr_par_err (adr_par_err),
    .nxm         (nxm),
    .mbx         (mbx_bus.ctl)
  );

  // Bus translator
  mt0 u_mt0 (
    .sbus_clk (sbus_clk),
    .reset    (reset),
    .mbx      (mbx_bus.xlat),
    .sbus     (sbus_bus.mbox)
  );

  // Single memory module
  sbus_mem u_mem (
    .sbus_clk (sbus_clk),
    .reset    (reset),
    .sbus     (sbus_bus.mem)
  );

endmodule

/* testbench/kl_mem_tb.sv */
module kl_mem_tb;
  import kl_mem_pkg::*;

  // Clock, reset and run length
  localparam int clk_period   = 100;
  localparam int reset_cycles = 16;
  localparam int done_limit   = 20;
  localparam int fixed_lat    = 1 + ackn_delay + data_delay + 1;

  // Requests per test, summed for the watchdog
  localparam int n_rand     = 40;
  localparam int n_fresh    = 4;
  localparam int n_bad_data = 4;
  localparam int n_bad_adr  = 2;
  localparam int n_nxm      = 3;
  localparam int n_busy     = 2;
  localparam int total_requests = 2 * n_rand + n_fresh + n_bad_data + n_bad_adr + n_nxm + n_busy;
  localparam int watchdog_time  = total_requests * 25 * clk_period + reset_cycles * clk_period;

  // Expected outcome of one request
  typedef struct packed {
    word_t rdata;
    logic  par_err;
    logic  adr_par_err;
    logic  nxm;
  } result_t;

  logic  sbus_clk;
  logic  reset;
  logic  rq;
  logic  wr;
  pma_t  addr;
  word_t wdata;
  diag_t diag;
  logic  busy;
  logic  done;
  word_t rdata;
  logic  par_err;
  logic  adr_par_err;
  logic  nxm;

  // Reference memory, words and bad-parity marks
  word_t ref_word [pma_t];
  logic  ref_bad  [pma_t];

  result_t want_q [$];
  int      id_q   [$];
  int      req_id;
  int      check_errs;
  int      proto_errs;
  integer  seed;
  pma_t    addr_list [n_rand];

  kl_mem_top dut (
    .sbus_clk    (sbus_clk),
    .reset       (reset),
    .rq          (rq),
    .wr          (wr),
    .addr        (addr),
    .wdata       (wdata),
    .diag        (diag),
    .busy        (busy),
    .done        (done),
    .rdata       (rdata),
    .par_err     (par_err),
    .adr_par_err (adr_par_err),
    .nxm         (nxm)
  );

  initial begin
    sbus_clk = 1'b0;
    forever #(clk_period / 2) sbus_clk = ~sbus_clk;
  end

  // Expected result from the memory rules and the reference contents
  function automatic result_t expect_result(input logic w, input pma_t a, input diag_t g);
    result_t r;
    r = '0;
    if (a >= pma_t'(mem_words)) begin
      r.nxm = 1'b1;
    end else if (g == diag_adr_par_inv) begin
      // Memory refuses the cycle at the acknowledge
      r.adr_par_err = 1'b1;
    end else if (!w && ref_word.exists(a)) begin
      r.rdata   = ref_word[a];
      r.par_err = ref_bad[a];
    end
    return r;
  endfunction

  // Only writes that the memory takes change the model
  task automatic update_model(input logic w, input pma_t a, input word_t d, input diag_t g);
    if (w && a < pma_t'(mem_words) && g != diag_adr_par_inv) begin
      ref_word[a] = d;
      ref_bad[a]  = (g == diag_data_par_inv);
    end
  endtask

  function automatic pma_t pick_addr();
    return pma_t'($unsigned($random(seed)) % mem_words);
  endfunction

  function automatic word_t pick_word();
    return word_t'({$random(seed), $random(seed)});
  endfunction

  task automatic check_word(input int id, input string what, input word_t got, input word_t exp);
    if (got !== exp) begin
      check_errs++;
      $display("CHECK FAILED at %0t: req %0d %s got %h expected %h", $time, id, what, got, exp);
    end
  endtask

  task automatic check_flag(input int id, input string what, input logic got, input logic exp);
    if (got !== exp) begin
      check_errs++;
      $display("CHECK FAILED at %0t: req %0d %s got %b expected %b", $time, id, what, got, exp);
    end
  endtask

  task automatic check_latency(input int id, input int got, input int exp);
    if (got != exp) begin
      check_errs++;
      $display("CHECK FAILED at %0t: req %0d latency got %0d expected %0d", $time, id, got, exp);
    end
  endtask

  // Waits for done, optionally pokes a second rq while busy
  task automatic await_done(input logic timed, input logic stray, input pma_t stray_addr);
    int   cycles;
    logic seen;
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < done_limit) begin
      @(negedge sbus_clk);
      cycles++;
      if (cycles == 1) rq = 1'b0;
      if (stray && cycles == 3) begin
        if (!busy) begin
          proto_errs++;
          $display("ERROR at %0t: busy was low when the extra request was driven", $time);
        end
        rq    = 1'b1;
        wr    = 1'b1;
        addr  = stray_addr;
        wdata = ~pick_word();
      end
      if (stray && cycles == 4) rq = 1'b0;
      seen = done;
    end
    if (!seen) begin
      proto_errs++;
      $display("ERROR at %0t: request %0d got no done within %0d cycles of rq",
               $time, req_id, done_limit);
    end else if (timed) begin
      check_latency(req_id, cycles, fixed_lat);
    end
  endtask

  task automatic run_request(input logic w, input pma_t a, input word_t d, input diag_t g,
                             input logic stray, input pma_t stray_addr);
    logic timed;
    @(negedge sbus_clk);
    while (busy) @(negedge sbus_clk);
    rq    = 1'b1;
    wr    = w;
    addr  = a;
    wdata = d;
    diag  = g;
    req_id++;
    want_q.push_back(expect_result(w, a, g));
    id_q.push_back(req_id);
    update_model(w, a, d, g);
    // Latency is fixed only for existing memory with clean parity
    timed = (a < pma_t'(mem_words)) && (g == 2'd0);
    await_done(timed, stray, stray_addr);
  endtask

  task automatic write_word(input pma_t a, input word_t d, input diag_t g);
    run_request(1'b1, a, d, g, 1'b0, '0);
  endtask

  task automatic read_word(input pma_t a);
    run_request(1'b0, a, '0, 2'd0, 1'b0, '0);
  endtask

  // Compare every done against the oldest outstanding request
  always @(negedge sbus_clk) begin
    result_t want;
    int      id;
    if (!reset && done) begin
      if (want_q.size() == 0) begin
        proto_errs++;
        $display("ERROR at %0t: done pulsed with no request outstanding", $time);
      end else begin
        want = want_q.pop_front();
        id   = id_q.pop_front();
        check_word(id, "rdata", rdata, want.rdata);
        check_flag(id, "par_err", par_err, want.par_err);
        check_flag(id, "adr_par_err", adr_par_err, want.adr_par_err);
        check_flag(id, "nxm", nxm, want.nxm);
        // Busy drops together with done
        check_flag(id, "busy", busy, 1'b0);
      end
    end
  end

  // Hard stop in case a wait never ends
  initial begin
    #(watchdog_time);
    $display("Watchdog expired at %0t, the run did not finish in time", $time);
    $display("FAIL: see errors above");
    $finish;
  end

  initial begin
    pma_t  a;
    word_t d;
    rq         = 1'b0;
    wr         = 1'b0;
    addr       = '0;
    wdata      = '0;
    diag       = '0;
    reset      = 1'b1;
    req_id     = 0;
    check_errs = 0;
    proto_errs = 0;
    seed       = 48;
    repeat (reset_cycles) @(negedge sbus_clk);
    reset = 1'b0;

    // Random writes, then read each address back
    for (int i = 0; i < n_rand; i++) begin
      addr_list[i] = pick_addr();
      write_word(addr_list[i], pick_word(), 2'd0);
    end
    for (int i = 0; i < n_rand; i++) begin
      read_word(addr_list[i]);
    end
    // Untouched words read as zero
    for (int i = 0; i < n_fresh; i++) begin
      a = pick_addr();
      while (ref_word.exists(a)) a = pick_addr();
      read_word(a);
    end

    // Bad data parity sticks until a clean write
    a = pick_addr();
    while (ref_word.exists(a)) a = pick_addr();
    write_word(a, pick_word(), diag_data_par_inv);
    read_word(a);
    write_word(a, pick_word(), 2'd0);
    read_word(a);

    // Bad address parity leaves the old word in place
    write_word(addr_list[0], pick_word(), diag_adr_par_inv);
    read_word(addr_list[0])
;

    // Nonexistent memory, then one existing word is still intact
    d = pick_word();
    run_request(1'b0, pma_t'(mem_words) + pma_t'(pick_addr()), '0, 2'd0, 1'b0, '0);
    // NXM write whose low address bits match the word read back next
    write_word(pma_t'(mem_words) + addr_list[1], d, 2'd0);
    read_word(addr_list[1]);

    // Extra rq during a busy read is dropped
    run_request(1'b0, addr_list[2], '0, 2'd0, 1'b1, addr_list[3]);
    read_word(addr_list[3]);

    // Room for a stray done to show up
    repeat (30) @(negedge sbus_clk);
    $display("Errors: %0d check, %0d protocol", check_errs, proto_errs);
    if (check_errs == 0 && proto_errs == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

/* compile.f */
hdl/kl_mem_pkg.sv
hdl/mbox_if.sv
hdl/sbus_if.sv
hdl/mbox_mem_ctl.sv
hdl/mt0.sv
hdl/sbus_mem.sv
hdl/kl_mem_top.sv
testbench/kl_mem_tb.sv

/* Makefile */
# Verilator build and run for the KL10 memory path model

VERILATOR ?= verilator
TOP       ?= kl_mem_tb
FILELIST  ?= compile.f
MDIR      ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= PASS: all tests

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(MDIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(MDIR) -f $(FILELIST)

# Pass only when the run exits cleanly and prints the pass line
run: $(BIN)
	@out="$$(./$(BIN))"; status=$$?; echo "$$out"; \
	if [ $$status -eq 0 ] && echo "$$out" | grep -qxF '$(PASS_TEXT)'; then \
	  echo "Simulation passed"; \
	else \
	  echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(MDIR)
